// File: design/elink_pkg.sv
`default_nettype none

package elink_pkg;

  localparam int FRAME_BYTES = 10;  // Last byte carries 4 data bits

  typedef logic [75:0] frame_t;
  typedef logic [7:0] byte_t;
  typedef logic [9:0] sym_t;  // Bit 0 is line bit a, sent first

  typedef enum logic [1:0] {
    CK_DATA = 2'b00,
    CK_SOP  = 2'b01,
    CK_EOP  = 2'b10,
    CK_IDLE = 2'b11
  } char_kind_e;

  // Control characters
  localparam byte_t K_SOP  = 8'hFB;  // K27.7
  localparam byte_t K_EOP  = 8'hFD;  // K29.7
  localparam byte_t K_IDLE = 8'hBC;  // K28.5

  // Comma prefix abcdeif, bit a in position 0
  localparam logic [6:0] COMMA_NEG = 7'b1111100;
  localparam logic [6:0] COMMA_POS = 7'b0000011;

  localparam logic [5:0] K28_6B = 6'b001111;  // K28 abcdei, RD- form
  localparam logic [3:0] A7_4B  = 4'b0111;    // Alternate x.7 fghj, RD- form

  // 5b/6b codes in RD- form, written abcdei
  localparam logic [5:0] D6_TABLE [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001,
    6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100,
    6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010,
    6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110,
    6'b001110, 6'b101110, 6'b011110, 6'b101011
  };

  // 3b/4b codes in RD- form, written fghj, primary x.7
  localparam logic [3:0] D4_TABLE [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100,
    4'b1101, 4'b1010, 4'b0110, 4'b1110
  };

endpackage

`default_nettype wire

// File: design/elink_char_if.sv
`timescale 1ns/1ns
`default_nettype none

// One character per valid/ready handshake
interface elink_char_if import elink_pkg::*; ();

  byte_t      data;
  char_kind_e kind;
  logic       valid;
  logic       ready;

  modport src (
    output data, kind, valid,
    input  ready
  );

  modport snk (
    input  data, kind, valid,
    output ready
  );

endinterface

`default_nettype wire

// File: design/frame_framer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_framer import elink_pkg::*; (
  input  logic   clk_40,
  input  logic   rst,
  input  frame_t frame,
  input  logic   frame_valid,
  output logic   frame_ready,
  elink_char_if.src chr
);

  localparam logic [3:0] EOP_IDX = 4'(FRAME_BYTES + 1);

  logic busy;
  logic [3:0] idx;  // 0 is SOP, then data bytes, then EOP
  frame_t frame_q;
  logic [FRAME_BYTES*8-1:0] padded;

  assign frame_ready = !busy;
  assign padded = (FRAME_BYTES*8)'(frame_q);  // Zero padding on top

  always_comb begin
    chr.valid = busy;
    if (idx == 4'd0) begin
      chr.kind = CK_SOP;
      chr.data = K_SOP;
    end else if (idx == EOP_IDX) begin
      chr.kind = CK_EOP;
      chr.data = K_EOP;
    end else begin
      chr.kind = CK_DATA;
      chr.data = padded[8 * (int'(idx) - 1) +: 8];  // Low byte first
    end
  end

  always_ff @(posedge clk_40) begin
    if (rst) begin
      busy <= 1'b0;
      idx <= '0;
    end else if (frame_valid && frame_ready) begin
      busy <= 1'b1;
      idx <= '0;
    end else if (chr.valid && chr.ready) begin
      if (idx == EOP_IDX)
        busy <= 1'b0;  // Ready again after EOP hand-off
      else
        idx <= idx + 4'd1;
    end
  end

  always_ff @(posedge clk_40) begin
    if (frame_valid && frame_ready) frame_q <= frame;
  end

endmodule

`default_nettype wire

// File: design/enc_8b10b.sv
`timescale 1ns/1ns
`default_nettype none

module enc_8b10b import elink_pkg::*; (
  input  logic clk_40,
  input  logic rst,
  input  logic sym_take,
  elink_char_if.snk chr,
  output sym_t sym
);

  logic rd;  // Running disparity, 1 is positive
  logic rd6;
  logic rd_next;
  logic is_k;
  logic k28;
  logic use_a7;
  logic alt6;
  logic alt4;
  byte_t ch;
  logic [4:0] x;
  logic [2:0] y;
  logic [5:0] c6;
  logic [5:0] e6;
  logic [3:0] c4;
  logic [3:0] e4;

  assign chr.ready = sym_take;

  always_comb begin
    // Idle comma whenever the framer has nothing to send
    ch = chr.valid ? chr.data : K_IDLE;
    is_k = !chr.valid || (chr.kind != CK_DATA);
    x = ch[4:0];
    y = ch[7:5];
    k28 = is_k && (x == 5'd28);

    // 5b/6b sub-block
    c6 = k28 ? K28_6B : D6_TABLE[x];
    alt6 = ($countones(c6) != 3) || (x == 5'd7 && !is_k);  // D.07 alternates too
    e6 = (rd && alt6) ? ~c6 : c6;
    rd6 = rd ^ ($countones(c6) != 3);

    // 3b/4b sub-block
    use_a7 = is_k ||
             (!rd6 && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
             (rd6 && (x == 5'd11 || x == 5'd13 || x == 5'd14));
    c4 = (y == 3'd7 && use_a7) ? A7_4B : D4_TABLE[y];
    if (k28)
      c4 = ~c4;  // K28 flips the balanced fghj codes
    alt4 = ($countones(c4) != 2) || (y == 3'd3) || k28;
    e4 = (rd6 && alt4) ? ~c4 : c4;
    rd_next = rd6 ^ ($countones(c4) != 2);
  end

  always_ff @(posedge clk_40) begin
    if (rst)
      rd <= 1'b0;
    else if (sym_take)
      rd <= rd_next;
  end

  // Line bit a ends up in sym[0]
  always_ff @(posedge clk_40) begin
    if (sym_take)
      sym <= {e4[0], e4[1], e4[2], e4[3], e6[0], e6[1], e6[2], e6[3], e6[4], e6[5]};
  end

endmodule

`default_nettype wire

// File: design/elink_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module elink_serializer import elink_pkg::*; #(
  parameter int serial_width = 2
) (
  input  logic clk_40,
  input  logic rst,
  input  sym_t sym,
  output logic sym_take,
  output logic [serial_width-1:0] serial
);

  localparam int SLOT = 10 / serial_width;  // Cycles per symbol

  logic [3:0] cnt;
  sym_t sr;

  assign sym_take = (cnt == 4'd0);  // Encoder updates sym on this edge
  assign serial = sr[serial_width-1:0];  // LSB first

  always_ff @(posedge clk_40) begin
    if (rst) begin
      cnt <= '0;
      sr <= '0;
    end else begin
      cnt <= (cnt == 4'(SLOT - 1)) ? 4'd0 : cnt + 4'd1;
      if (cnt == 4'd1)
        sr <= sym;  // New symbol one cycle after the take
      else
        sr <= sr >> serial_width;
    end
  end

endmodule

`default_nettype wire

// File: design/elink_deserializer.sv
`timescale 1ns/1ns
`default_nettype none

module elink_deserializer import elink_pkg::*; #(
  parameter int serial_width = 2
) (
  input  logic clk_40,
  input  logic rst,
  input  logic [serial_width-1:0] serial,
  output sym_t sym,
  output logic sym_valid,
  output logic locked
);

  localparam int SLOT = 10 / serial_width;

  logic [19:0] hist;  // Oldest bit at position 0
  logic [19:0] shifted;
  logic [3:0] cnt;
  logic [3:0] al_phase;  // Candidate or locked slot phase
  logic [3:0] al_off;    // Bit offset within the low lanes
  logic [3:0] found_off;
  logic al_valid;
  logic found;

  // Every stream bit passes the low serial_width positions exactly once
  always_comb begin
    found = 1'b0;
    found_off = '0;
    for (int i = serial_width - 1; i >= 0; i--) begin
      if (hist[i +: 7] == COMMA_NEG || hist[i +: 7] == COMMA_POS) begin
        found = 1'b1;
        found_off = 4'(i);
      end
    end
  end

  assign shifted = hist >> al_off;

  always_ff @(posedge clk_40) begin
    hist <= {serial, hist[19:serial_width]};
    sym <= shifted[9:0];
    if (found) begin
      al_phase <= cnt;
      al_off <= found_off;
    end
  end

  always_ff @(posedge clk_40) begin
    if (rst) begin
      cnt <= '0;
      al_valid <= 1'b0;
      locked <= 1'b0;
      sym_valid <= 1'b0;
    end else begin
      cnt <= (cnt == 4'(SLOT - 1)) ? 4'd0 : cnt + 4'd1;
      sym_valid <= locked && (cnt == al_phase);
      if (found) begin
        al_valid <= 1'b1;
        if (cnt != al_phase || found_off != al_off)
          locked <= 1'b0;  // Comma moved, start over from here
        else if (al_valid)
          locked <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/dec_8b10b.sv
`timescale 1ns/1ns
`default_nettype none

module dec_8b10b import elink_pkg::*; (
  input  logic clk_40,
  input  logic rst,
  input  sym_t sym,
  input  logic sym_valid,
  elink_char_if.src chr,
  output logic code_err
);

  logic rd;
  logic rd_ok;  // Disparity unknown until the first symbol
  logic rd6;
  logic rd_next;
  logic k28;
  logic a7;
  logic hit6;
  logic hit4;
  logic disp_err;
  logic is_k;
  logic [5:0] code6;
  logic [5:0] n6;
  logic [3:0] code4;
  logic [3:0] n4;
  logic [2:0] ones6;
  logic [2:0] ones4;
  logic [4:0] x;
  logic [2:0] y;

  always_comb begin
    code6 = {sym[0], sym[1], sym[2], sym[3], sym[4], sym[5]};
    code4 = {sym[6], sym[7], sym[8], sym[9]};
    ones6 = 3'($countones(code6));
    ones4 = 3'($countones(code4));

    // Fold back to the RD- form, then search the table
    n6 = (ones6 < 3'd3 || code6 == 6'b000111) ? ~code6 : code6;
    k28 = (n6 == K28_6B);
    x = 5'd28;
    hit6 = k28;
    for (int i = 0; i < 32; i++) begin
      if (D6_TABLE[i] == n6) begin
        x = 5'(i);
        hit6 = 1'b1;
      end
    end
    rd6 = (ones6 == 3'd3) ? rd : (ones6 == 3'd4);

    if (k28 && !rd6)
      n4 = ~code4;
    else if (ones4 < 3'd2 || code4 == 4'b0011)
      n4 = ~code4;
    else
      n4 = code4;
    a7 = (n4 == A7_4B);
    y = 3'd7;
    hit4 = a7;
    for (int j = 0; j < 8; j++) begin
      if (D4_TABLE[j] == n4) begin
        y = 3'(j);
        hit4 = 1'b1;
      end
    end

    is_k = k28 || (a7 && (x == 5'd27 || x == 5'd29));
    disp_err = (ones6 == 3'd4 && rd) || (ones6 == 3'd2 && !rd) ||
               (code6 == 6'b111000 && rd) || (code6 == 6'b000111 && !rd) ||
               (ones4 == 3'd3 && rd6) || (ones4 == 3'd1 && !rd6) ||
               (code4 == 4'b1100 && rd6) || (code4 == 4'b0011 && !rd6);
    rd_next = (ones4 == 3'd2) ? rd6 : (ones4 == 3'd3);
  end

  always_ff @(posedge clk_40) begin
    if (rst) begin
      rd <= 1'b0;
      rd_ok <= 1'b0;
      chr.valid <= 1'b0;
      code_err <= 1'b0;
    end else begin
      chr.valid <= 1'b0;
      code_err <= 1'b0;
      if (sym_valid) begin
        rd <= rd_next;  // Resyncs even after an error
        rd_ok <= 1'b1;
        code_err <= !hit6 || !hit4 || (rd_ok && disp_err) ||
                    (k28 && y != 3'd5);
        chr.valid <= hit6 && hit4 && !(k28 && y == 3'd5);  // Idle commas dropped
      end
    end
  end

  always_ff @(posedge clk_40) begin
    if (sym_valid) begin
      chr.data <= {y, x};
      if (!is_k)
        chr.kind <= CK_DATA;
      else if (x == 5'd27)
        chr.kind <= CK_SOP;
      else if (x == 5'd29)
        chr.kind <= CK_EOP;
      else
        chr.kind <= CK_IDLE;
    end
  end

endmodule

`default_nettype wire

// File: design/frame_deframer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_deframer import elink_pkg::*; (
  input  logic   clk_40,
  input  logic   rst,
  input  logic   code_err,
  elink_char_if.snk chr,
  output frame_t frame,
  output logic   frame_valid,
  output logic   frame_err
);

  logic active;
  logic err_seen;  // Code error since SOP
  logic take;
  logic good;
  logic [3:0] cnt;
  logic [FRAME_BYTES*8-1:0] bytes_q;

  assign take = chr.valid && chr.ready;
  assign good = active && (cnt == 4'(FRAME_BYTES)) && !err_seen && !code_err &&
                (bytes_q[FRAME_BYTES*8-1:$bits(frame_t)] == '0);  // Padding must be zero

  always_ff @(posedge clk_40) begin
    if (rst) begin
      active <= 1'b0;
      err_seen <= 1'b0;
      cnt <= '0;
      frame_valid <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      frame_valid <= 1'b0;
      frame_err <= 1'b0;
      if (code_err)
        err_seen <= 1'b1;
      if (take) begin
        case (chr.kind)
          CK_SOP: begin  // Also restarts a frame in progress
            active <= 1'b1;
            cnt <= '0;
            err_seen <= code_err;
          end
          CK_DATA: if (active && cnt != 4'hF) cnt <= cnt + 4'd1;
          CK_EOP: begin
            frame_valid <= good;
            frame_err <= !good;
            active <= 1'b0;
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_40) begin
    if (take && chr.kind == CK_DATA && cnt < 4'(FRAME_BYTES))
      bytes_q[8 * int'(cnt) +: 8] <= chr.data;
    if (take && chr.kind == CK_EOP && good)
      frame <= bytes_q[$bits(frame_t)-1:0];
  end

endmodule

`default_nettype wire

// File: design/elink_core.sv
`timescale 1ns/1ns
`default_nettype none

module elink_core import elink_pkg::*; #(
  parameter int serial_width = 2  // 1, 2 or 5
) (
  input  logic   clk_40,
  input  logic   rst,
  input  frame_t tx_frame,
  input  logic   tx_valid,
  output logic   tx_ready,
  input  logic   loop_en,
  input  logic [serial_width-1:0] serial_in,
  output logic [serial_width-1:0] serial_out,
  output frame_t rx_frame,
  output logic   rx_valid,
  output logic   rx_frame_err,
  output logic   rx_code_err,
  output logic   rx_locked
);

  sym_t tx_sym;
  sym_t rx_sym;
  logic sym_take;
  logic rx_sym_valid;
  logic [serial_width-1:0] rx_serial;

  elink_char_if tx_chr ();
  elink_char_if rx_chr ();

  assign rx_chr.ready = 1'b1;  // Receive side never stalls

  // Loopback select
  assign rx_serial = loop_en ? serial_out : serial_in;

  frame_framer framer0 (
    .clk_40(clk_40), .rst(rst), .frame(tx_frame), .frame_valid(tx_valid),
    .frame_ready(tx_ready), .chr(tx_chr.src)
  );

  enc_8b10b enc0 (
    .clk_40(clk_40), .rst(rst), .sym_take(sym_take), .chr(tx_chr.snk), .sym(tx_sym)
  );

  elink_serializer #(.serial_width(serial_width)) ser0 (
    .clk_40(clk_40), .rst(rst), .sym(tx_sym), .sym_take(sym_take), .serial(serial_out)
  );

  elink_deserializer #(.serial_width(serial_width)) des0 (
    .clk_40(clk_40), .rst(rst), .serial(rx_serial), .sym(rx_sym),
    .sym_valid(rx_sym_valid), .locked(rx_locked)
  );

  dec_8b10b dec0 (
    .clk_40(clk_40), .rst(rst), .sym(rx_sym), .sym_valid(rx_sym_valid),
    .chr(rx_chr.src), .code_err(rx_code_err)
  );

  frame_deframer deframer0 (
    .clk_40(clk_40), .rst(rst), .code_err(rx_code_err), .chr(rx_chr.snk),
    .frame(rx_frame), .frame_valid(rx_valid), .frame_err(rx_frame_err)
  );

endmodule

`default_nettype wire

// File: test/elink_checker.sv
`timescale 1ns/1ns
`default_nettype none

module elink_checker import elink_pkg::*; (
  input logic   clk_40,
  input logic   rst,
  input frame_t tx_frame,
  input logic   tx_valid,
  input logic   tx_ready,
  input logic   rx_valid,
  input logic   rx_frame_err,
  input logic   rx_code_err,
  input logic   rx_locked
);

  int n_errors = 0;  // Failed assertions so far

  // Reset state shows on the cycle after each reset cycle
  assert property (@(posedge clk_40) rst |=> tx_ready && !rx_valid && !rx_frame_err &&
                   !rx_code_err && !rx_locked)
    else begin
      n_errors++;
      $error("Outputs not in reset state");
    end

  assert property (@(posedge clk_40) disable iff (rst)
                   tx_valid && !tx_ready |=> $stable(tx_frame))
    else begin
      n_errors++;
      $error("tx_frame changed while waiting for tx_ready");
    end

  assert property (@(posedge clk_40) disable iff (rst) rx_valid |-> rx_locked)
    else begin
      n_errors++;
      $error("rx_valid without rx_locked");
    end

endmodule

bind elink_core elink_checker chk0 (
  .clk_40(clk_40), .rst(rst), .tx_frame(tx_frame), .tx_valid(tx_valid),
  .tx_ready(tx_ready), .rx_valid(rx_valid), .rx_frame_err(rx_frame_err),
  .rx_code_err(rx_code_err), .rx_locked(rx_locked)
);

`default_nettype wire

// File: test/elink_scoreboard.sv
`timescale 1ns/1ns
`default_nettype none

module elink_scoreboard import elink_pkg::*; (
  input  logic   clk_40,
  input  logic   rst,
  input  frame_t tx_frame,
  input  logic   tx_valid,
  input  logic   tx_ready,
  input  logic   inject,
  input  frame_t rx_frame,
  input  logic   rx_valid,
  input  logic   rx_frame_err,
  input  logic   rx_code_err,
  output int     n_pass,
  output int     n_fail,
  output int     n_pending
);

  localparam int FRAME_LIMIT = 400;  // Cycles a frame may stay at the head

  frame_t exp_q [$];
  logic bad_q [$];
  int id_q [$];
  int n_sent;
  int wait_cnt;
  logic took;          // Handshake on the previous edge
  logic err_expected;  // Further error pulses of a dropped frame

  task automatic drop_front();
    exp_q.delete(0);
    bad_q.delete(0);
    id_q.delete(0);
    wait_cnt = 0;
  endtask

  always @(posedge clk_40) begin
    if (rst) begin
      exp_q.delete();
      bad_q.delete();
      id_q.delete();
      n_pass = 0;
      n_fail = 0;
      n_sent = 0;
      wait_cnt = 0;
      took = 1'b0;
      err_expected = 1'b0;
    end else begin
      if (took && tx_ready) begin
        $display("Fail at %0t ns: tx_ready expected 0, got 1 after acceptance", $time);
        n_fail++;
      end
      took = tx_valid && tx_ready;
      if (took) begin
        exp_q.push_back(tx_frame);
        bad_q.push_back(inject);
        id_q.push_back(n_sent);
        n_sent++;
      end

      if (rx_valid) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected frame on rx_frame at %0t ns, none outstanding", $time);
          n_fail++;
        end else if (bad_q[0]) begin
          $display("Test %0d: frame with a line error was delivered", id_q[0]);
          n_fail++;
          drop_front();
        end else if (rx_frame !== exp_q[0]) begin
          $display("Fail at %0t ns: test %0d rx_frame expected %h, got %h",
                   $time, id_q[0], exp_q[0], rx_frame);
          n_fail++;
          drop_front();
        end else begin
          $display("Test %0d passed: rx_frame %h", id_q[0], rx_frame);
          n_pass++;
          drop_front();
        end
        err_expected = 1'b0;
      end

      if (rx_code_err || rx_frame_err) begin
        if (exp_q.size() != 0 && bad_q[0]) begin
          $display("Test %0d passed: line error flagged, frame dropped", id_q[0]);
          n_pass++;
          drop_front();
          err_expected = 1'b1;
        end else if (!err_expected) begin
          $display("Unexpected receiver error at %0t ns (rx_code_err %b, rx_frame_err %b)",
                   $time, rx_code_err, rx_frame_err);
          n_fail++;
        end
      end

      if (exp_q.size() == 0) begin
        wait_cnt = 0;
      end else if (wait_cnt == FRAME_LIMIT) begin
        $display("Test %0d timed out after %0d cycles, frame lost", id_q[0], FRAME_LIMIT);
        n_fail++;
        drop_front();
      end else begin
        wait_cnt++;
      end
    end
    n_pending = exp_q.size();
  end

endmodule

`default_nettype wire

// File: test/tb_elink_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_elink_core import elink_pkg::*; ();

  localparam int SW = 2;
  localparam int NUM_TESTS = 8;
  localparam int LOCK_LIMIT = 200;   // Cycles
  localparam int READY_LIMIT = 200;
  localparam int DRAIN_LIMIT = 1000;

  typedef struct {
    frame_t frame;   // Sent, and expected back unchanged
    logic   loop;    // 1 selects internal loopback
    logic   inject;  // Flip one line bit, expect an error and no delivery
    int     gap;     // Cycles with tx_valid low before sending
  } entry_t;

  logic clk_40;
  logic rst;
  frame_t tx_frame;
  logic tx_valid;
  logic tx_ready;
  logic loop_en;
  logic [SW-1:0] serial_in;
  logic [SW-1:0] serial_out;
  frame_t rx_frame;
  logic rx_valid;
  logic rx_frame_err;
  logic rx_code_err;
  logic rx_locked;
  logic inject;
  logic aborted;
  int flip_cnt;
  int tb_pass;
  int tb_fail;
  int n_pass;
  int n_fail;
  int n_pending;
  integer seed = 32'he60f_789d;
  entry_t table_e [NUM_TESTS];

  elink_core #(.serial_width(SW)) dut0 (
    .clk_40(clk_40), .rst(rst), .tx_frame(tx_frame), .tx_valid(tx_valid),
    .tx_ready(tx_ready), .loop_en(loop_en), .serial_in(serial_in),
    .serial_out(serial_out), .rx_frame(rx_frame), .rx_valid(rx_valid),
    .rx_frame_err(rx_frame_err), .rx_code_err(rx_code_err), .rx_locked(rx_locked)
  );

  elink_scoreboard sb0 (
    .clk_40(clk_40), .rst(rst), .tx_frame(tx_frame), .tx_valid(tx_valid),
    .tx_ready(tx_ready), .inject(inject), .rx_frame(rx_frame), .rx_valid(rx_valid),
    .rx_frame_err(rx_frame_err), .rx_code_err(rx_code_err),
    .n_pass(n_pass), .n_fail(n_fail), .n_pending(n_pending)
  );

  initial clk_40 = 1'b0;
  always #10 clk_40 = ~clk_40;

  // External link model, one register stage
  always @(negedge clk_40) serial_in <= serial_out ^ SW'(flip_cnt == 1);

  // Counted from the accepting edge so the flip lands among the data bytes
  always @(posedge clk_40) begin
    if (rst)
      flip_cnt <= 0;
    else if (tx_valid && tx_ready && inject)
      flip_cnt <= 20;
    else if (flip_cnt != 0)
      flip_cnt <= flip_cnt - 1;
  end

  function automatic frame_t rand_frame();
    logic [95:0] r;
    r[31:0] = $random(seed);
    r[63:32] = $random(seed);
    r[95:64] = $random(seed);
    return r[75:0];
  endfunction

  task automatic load_table();
    table_e[0] = '{76'h0, 1'b1, 1'b0, 4};
    table_e[1] = '{{76{1'b1}}, 1'b1, 1'b0, 0};  // Entries 1 to 3 back to back
    table_e[2] = '{rand_frame(), 1'b1, 1'b0, 0};
    table_e[3] = '{76'hA_5A5A5A_5A5A5A_5A5A5A, 1'b1, 1'b0, 0};
    table_e[4] = '{76'h3_012345_6789AB_CDEF01, 1'b0, 1'b0, 30};
    table_e[5] = '{rand_frame(), 1'b0, 1'b1, 30};
    table_e[6] = '{rand_frame(), 1'b0, 1'b0, 100};  // Idle commas after the bad frame
    table_e[7] = '{76'h8_000000_000000_000001, 1'b1, 1'b0, 20};
  endtask

  task automatic wait_lock();
    int t;
    t = 0;
    while (!rx_locked && t < LOCK_LIMIT) begin
      @(negedge clk_40);
      t++;
    end
    if (rx_locked) begin
      $display("Test lock passed: rx_locked rose %0d cycles after reset", t);
      tb_pass++;
    end else begin
      $display("Test lock: rx_locked did not rise within %0d cycles", LOCK_LIMIT);
      tb_fail++;
      aborted = 1'b1;
    end
  endtask

  task automatic send_frame(input entry_t e);
    int t;
    if (e.gap > 0) begin
      tx_valid = 1'b0;
      repeat (e.gap) @(negedge clk_40);
    end
    loop_en = e.loop;
    inject = e.inject;
    tx_frame = e.frame;
    tx_valid = 1'b1;
    t = 0;
    while (!tx_ready && t < READY_LIMIT) begin
      @(negedge clk_40);
      t++;
    end
    if (!tx_ready) begin
      $display("Timeout at %0t ns: tx_ready stayed low, frame was not accepted", $time);
      tb_fail++;
      aborted = 1'b1;
    end else begin
      @(negedge clk_40);  // Accepted on the rising edge in between
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (n_pending != 0 && t < DRAIN_LIMIT) begin
      @(negedge clk_40);
      t++;
    end
    if (n_pending != 0) begin
      $display("Timeout at %0t ns: %0d frames still outstanding", $time, n_pending);
      tb_fail++;
    end
    repeat (20) @(negedge clk_40);  // Catch stray frames
  endtask

  task automatic report();
    int total_fail;
    total_fail = tb_fail + n_fail + dut0.chk0.n_errors;
    $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
             tb_pass + n_pass, tb_fail + n_fail, dut0.chk0.n_errors);
    if (total_fail == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  endtask

  initial begin
    rst = 1'b1;
    tx_frame = '0;
    tx_valid = 1'b0;
    loop_en = 1'b1;
    inject = 1'b0;
    serial_in = '0;
    tb_pass = 0;
    tb_fail = 0;
    aborted = 1'b0;
    load_table();
    repeat (8) @(negedge clk_40);
    rst = 1'b0;
    wait_lock();
    for (int i = 0; i < NUM_TESTS && !aborted; i++)
      send_frame(table_e[i]);
    tx_valid = 1'b0;
    if (!aborted)
      wait_drain();
    report();
  end

endmodule

`default_nettype wire

// File: files.f
design/elink_pkg.sv
design/elink_char_if.sv
design/frame_framer.sv
design/enc_8b10b.sv
design/elink_serializer.sv
design/elink_deserializer.sv
design/dec_8b10b.sv
design/frame_deframer.sv
design/elink_core.sv
test/elink_checker.sv
test/elink_scoreboard.sv
test/tb_elink_core.sv

// File: Bender.yml
package:
  name: elink_core

sources:
  - design/elink_pkg.sv
  - design/elink_char_if.sv
  - design/frame_framer.sv
  - design/enc_8b10b.sv
  - design/elink_serializer.sv
  - design/elink_deserializer.sv
  - design/dec_8b10b.sv
  - design/frame_deframer.sv
  - design/elink_core.sv
  - target: test
    files:
      - test/elink_checker.sv
      - test/elink_scoreboard.sv
      - test/tb_elink_core.sv
